// ==== dv/tb_test_node_client.sv ====
// Testbench for the test node client
// Drives cache packets through the request port and checks every
// response against a shadow copy of the backing memory. Covers
// reset state, cold misses, hit latency, masked stores, dirty
// eviction, response back-pressure and a random load/store mix

`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module tb_test_node_client
  import cache_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 220 * 40 + 500;

  logic        clock;
  logic        rst_n;
  logic        v_in;
  logic [79:0] data_in;
  logic        ready_out;
  logic        v_out;
  logic [31:0] data_out;
  logic        yumi_in;

  int          cycle;
  int          n_checks;
  int          n_errors;
  int          accept_cycle;
  int          resp_latency;
  logic [31:0] shadow [`MEM_WORDS];

  test_node_client i_dut (
    .clock_i (clock),
    .rst_n_i (rst_n),
    .v_i     (v_in),
    .data_i  (data_in),
    .ready_o (ready_out),
    .v_o     (v_out),
    .data_o  (data_out),
    .yumi_i  (yumi_in)
  );

  always #4 clock = ~clock;

  // ====================
  // run control
  task automatic finish_run;
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  always @(posedge clock) begin
    cycle = cycle + 1;
    if (cycle == TIMEOUT_CYCLES) begin
      $display("timeout: the DUT stopped answering after %0d cycles", cycle);
      n_errors++;
      finish_run();
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      n_errors++;
    end
  endtask

  // ====================
  // bus tasks
  task automatic send_req(input cache_op_e op, input logic [3:0] mask,
                          input logic [31:0] addr, input logic [31:0] data);
    cache_pkt_s pkt;
    pkt.opcode = op;
    pkt.mask   = mask;
    pkt.addr   = addr;
    pkt.data   = data;
    data_in = {6'($urandom), pkt};  // top bits are don't-care
    v_in    = 1'b1;
    while (!ready_out) begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);  // accepting edge
    #1;
    accept_cycle = cycle;
    v_in = 1'b0;
  endtask

  task automatic get_resp(input string name, input int stall, output logic [31:0] resp);
    logic [31:0] held;
    while (!v_out) begin
      @(posedge clock);
      #1;
    end
    resp_latency = cycle - accept_cycle;
    held = data_out;
    for (int i = 0; i < stall; i++) begin
      @(posedge clock);
      #1;
      check({name, " v_o held"}, 32'd1, 32'(v_out));
      check({name, " data_o held"}, held, data_out);
      check({name, " ready_o low"}, 32'd0, 32'(ready_out));
    end
    yumi_in = 1'b1;
    @(posedge clock);
    #1;
    yumi_in = 1'b0;
    check({name, " ready_o after yumi"}, 32'd1, 32'(ready_out));
    resp = held;
  endtask

  // one request through the DUT, compared with the shadow memory
  task automatic do_op(input string name, input cache_op_e op, input logic [3:0] mask,
                       input logic [31:0] addr, input logic [31:0] data, input int stall);
    logic [31:0] exp;
    logic [31:0] act;
    int          w;
    w   = int'(addr[31:2]) % `MEM_WORDS;
    exp = shadow[w];
    if (op == OP_SW) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) exp[8*b +: 8] = data[8*b +: 8];
      end
      shadow[w] = exp;
    end
    send_req(op, mask, addr, data);
    get_resp(name, stall, act);
    check(name, exp, act);
  endtask

  // ====================
  // directed tests
  task automatic test_reset;
    check("test_reset ready_o", 32'd1, 32'(ready_out));
    check("test_reset v_o", 32'd0, 32'(v_out));
  endtask

  task automatic test_cold_load;
    logic [31:0] addr;
    for (int i = 0; i < 8; i++) begin
      addr = 32'h400 + 32'(i << 5) + 32'((i % 4) << 2);  // sets 0,2,..,14
      do_op("test_cold_load miss", OP_LW, 4'h0, addr, 32'h0, 0);
    end
    do_op("test_cold_load hit", OP_LW, 4'h0, 32'h404, 32'h0, 0);
    check("test_cold_load hit latency", 32'd2, 32'(resp_latency));
  endtask

  task automatic test_store_mask;
    logic [3:0] masks [4];
    masks = '{4'hf, 4'h1, 4'h6, 4'h0};
    for (int i = 0; i < 4; i++) begin
      do_op("test_store_mask store", OP_SW, masks[i], 32'h48, $urandom, 0);
      do_op("test_store_mask load", OP_LW, 4'h0, 32'h48, 32'h0, 0);
    end
  endtask

  task automatic test_evict;
    do_op("test_evict store", OP_SW, 4'hf, 32'h130, 32'hdeadbeef, 0);
    do_op("test_evict conflict", OP_LW, 4'h0, 32'h230, 32'h0, 0);  // same set, new tag
    do_op("test_evict reload", OP_LW, 4'h0, 32'h130, 32'h0, 0);
  endtask

  task automatic test_backpressure;
    for (int i = 0; i < 4; i++) begin
      do_op("test_backpressure", (i % 2 == 0) ? OP_SW : OP_LW, 4'(i + 3),
            32'h500 + 32'(i << 2), $urandom, $urandom_range(8, 1));
    end
  endtask

  task automatic test_random_mix;
    cache_op_e op;
    for (int i = 0; i < 200; i++) begin
      op = ($urandom % 2 == 0) ? OP_LW : OP_SW;
      do_op("test_random_mix", op, 4'($urandom), $urandom % 2048, $urandom,
            $urandom_range(2, 0));
    end
  endtask

  // ====================
  // main sequence
  initial begin
    clock    = 1'b0;
    rst_n    = 1'b0;
    v_in     = 1'b0;
    data_in  = '0;
    yumi_in  = 1'b0;
    cycle    = 0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'h8a83));  // seed once

    for (int i = 0; i < `MEM_WORDS; i++) begin
      shadow[i] = 32'(i) ^ 32'h5a5a0000;
    end

    repeat (3) @(posedge clock);
    #1;
    rst_n = 1'b1;

    test_reset();
    test_cold_load();
    test_store_mask();
    test_evict();
    test_backpressure();
    test_random_mix();

    finish_run();
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/cache_pkg.sv
src/dma_pkg.sv
src/dma_if.sv
src/cache_ctrl.sv
src/mock_memory.sv
src/test_node_client.sv
dv/tb_test_node_client.sv

// ==== src/cache_ctrl.sv ====
// Blocking direct-mapped write-back data cache
// One request at a time. A miss writes back a dirty victim and
// fills the line over the DMA link before the response is built.
// Loads return the addressed word, stores return the merged word

`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_ctrl
  import cache_pkg::*;
  import dma_pkg::*;
(
  input  wire             clock_i,
  input  wire             rst_n_i,

  input  wire cache_pkt_s pkt_i,
  input  wire             v_i,
  output logic            ready_o,

  output logic            v_o,
  output logic [`CACHE_WORD_W-1:0] data_o,
  input  wire             yumi_i,

  dma_if.cache            dma
);

  localparam int IDX_W   = $clog2(`CACHE_SETS);
  localparam int OFF_W   = $bits(dma_cnt_t);
  localparam int TAG_W   = `CACHE_ADDR_W - IDX_W - OFF_W - 2;
  localparam int BYTES   = `CACHE_WORD_W / 8;
  localparam dma_cnt_t LAST = dma_cnt_t'(`CACHE_BLOCK_WORDS - 1);

  // ====================
  // state and storage
  cache_state_e state;
  dma_cnt_t     cnt;          // word within the block being moved
  cache_pkt_s   pkt_r;
  logic         v_o_r;
  logic [`CACHE_WORD_W-1:0] data_o_r;

  logic [`CACHE_WORD_W-1:0] data_mem [`CACHE_SETS*`CACHE_BLOCK_WORDS];
  logic [TAG_W-1:0]         tag_mem  [`CACHE_SETS];
  logic [`CACHE_SETS-1:0]   valid_r;
  logic [`CACHE_SETS-1:0]   dirty_r;

  logic [TAG_W-1:0] tag;
  logic [IDX_W-1:0] idx;
  dma_cnt_t         off;
  logic             hit;
  logic             is_store;
  logic [`CACHE_WORD_W-1:0] merged;

  assign tag = pkt_r.addr[`CACHE_ADDR_W-1 -: TAG_W];
  assign idx = pkt_r.addr[OFF_W+2 +: IDX_W];
  assign off = pkt_r.addr[2 +: OFF_W];

  assign hit      = valid_r[idx] && (tag_mem[idx] == tag);
  assign is_store = (pkt_r.opcode == OP_SW);

  // byte merge of store data into the cached word
  always_comb begin
    merged = data_mem[{idx, off}];
    if (is_store) begin
      for (int b = 0; b < BYTES; b++) begin
        if (pkt_r.mask[b]) merged[8*b +: 8] = pkt_r.data[8*b +: 8];
      end
    end
  end

  // ====================
  // control FSM
  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      state   <= S_IDLE;
      cnt     <= '0;
      v_o_r   <= 1'b0;
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      if (v_o_r && yumi_i) v_o_r <= 1'b0;  // response taken

      case (state)
        S_IDLE: begin
          if (v_i && ready_o) state <= S_LOOKUP;
        end
        S_LOOKUP: begin
          if (hit) begin
            state <= S_RESP;
          end else if (valid_r[idx] && dirty_r[idx]) begin
            state <= S_WB_REQ;       // evict dirty victim first
          end else begin
            state <= S_FILL_REQ;
          end
        end
        S_WB_REQ: begin
          if (dma.req_yumi) begin
            state <= S_WB_DATA;
            cnt   <= '0;
          end
        end
        S_WB_DATA: begin
          if (dma.wr_yumi) begin
            cnt <= cnt + dma_cnt_t'(1);
            if (cnt == LAST) state <= S_FILL_REQ;
          end
        end
        S_FILL_REQ: begin
          if (dma.req_yumi) begin
            state <= S_FILL_DATA;
            cnt   <= '0;
          end
        end
        S_FILL_DATA: begin
          if (dma.rd_v) begin
            cnt <= cnt + dma_cnt_t'(1);
            if (cnt == LAST) begin
              state        <= S_RESP;
              valid_r[idx] <= 1'b1;
              dirty_r[idx] <= 1'b0;
            end
          end
        end
        S_RESP: begin
          v_o_r <= 1'b1;
          state <= S_IDLE;
          if (is_store) dirty_r[idx] <= 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ====================
  // datapath
  always_ff @(posedge clock_i) begin
    if (v_i && ready_o) pkt_r <= pkt_i;

    if (state == S_FILL_DATA && dma.rd_v) begin
      data_mem[{idx, cnt}] <= dma.rd_data;
      if (cnt == LAST) tag_mem[idx] <= tag;
    end

    if (state == S_RESP) begin
      data_o_r <= merged;
      if (is_store) data_mem[{idx, off}] <= merged;
    end
  end

  assign ready_o = (state == S_IDLE) && !v_o_r;
  assign v_o     = v_o_r;
  assign data_o  = data_o_r;

  // dma side, victim address comes from the stored tag
  assign dma.req_v              = (state == S_WB_REQ) || (state == S_FILL_REQ);
  assign dma.req_write_not_read = (state == S_WB_REQ);
  assign dma.req_addr = (state == S_WB_REQ) ? {tag_mem[idx], idx, {(OFF_W+2){1'b0}}}
                                            : {tag, idx, {(OFF_W+2){1'b0}}};
  assign dma.rd_ready = (state == S_FILL_DATA);
  assign dma.wr_v     = (state == S_WB_DATA);
  assign dma.wr_data  = data_mem[{idx, cnt}];

  // ====================
  // checks
  a_legal_op: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (v_i && ready_o) |-> (pkt_i.opcode inside {OP_LW, OP_SW}))
    else $error("illegal opcode accepted");

  a_resp_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (v_o && !yumi_i) |=> (v_o && $stable(data_o)))
    else $error("response dropped or changed before yumi");

  a_ready_after_yumi: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (v_o && yumi_i) |=> ready_o)
    else $error("ready_o did not return after the response was taken");

endmodule

`default_nettype wire

// ==== src/cache_defines.svh ====
// Cache and memory geometry
// Widths, cache shape and mock memory size and latency, shared by
// the RTL and the testbench

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ====================
// widths
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// ====================
// cache geometry
`define CACHE_SETS 16
`define CACHE_BLOCK_WORDS 4   // words per line

// ====================
// mock memory
`define MEM_WORDS 1024
`define MEM_LATENCY 4         // accepted read request to first read word

`endif

// ==== src/cache_pkg.sv ====
// Cache request package
// Opcodes and packet layout of a cache request, plus the
// states of the cache controller

`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

  typedef enum logic [5:0] {
    OP_LW = 6'd0,  // word load
    OP_SW = 6'd1   // store under byte mask
  } cache_op_e;

  // packed from the top down, maps onto request bits 73:0
  typedef struct packed {
    cache_op_e                   opcode;
    logic [`CACHE_WORD_W/8-1:0]  mask;
    logic [`CACHE_ADDR_W-1:0]    addr;
    logic [`CACHE_WORD_W-1:0]    data;
  } cache_pkt_s;

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_WB_REQ, S_WB_DATA, S_FILL_REQ, S_FILL_DATA, S_RESP
  } cache_state_e;

endpackage

`default_nettype wire

// ==== src/dma_if.sv ====
// DMA link
// Request, read data and write data channels between the cache
// and the backing memory. The request and write channels use
// valid/yumi, the read channel uses valid/ready

`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

interface dma_if;

  // ====================
  // request channel
  logic                     req_v;
  logic                     req_write_not_read;
  logic [`CACHE_ADDR_W-1:0] req_addr;    // block aligned
  logic                     req_yumi;

  // ====================
  // read channel
  logic                     rd_v;
  logic [`CACHE_WORD_W-1:0] rd_data;
  logic                     rd_ready;

  // ====================
  // write channel
  logic                     wr_v;
  logic [`CACHE_WORD_W-1:0] wr_data;
  logic                     wr_yumi;

  modport cache (
    output req_v, req_write_not_read, req_addr, input req_yumi,
    input rd_v, rd_data, output rd_ready,
    output wr_v, wr_data, input wr_yumi
  );

  modport mem (
    input req_v, req_write_not_read, req_addr, output req_yumi,
    output rd_v, rd_data, input rd_ready,
    input wr_v, wr_data, output wr_yumi
  );

endinterface

`default_nettype wire

// ==== src/dma_pkg.sv ====
// DMA side package
// Mock memory states and the word counter used to walk a block

`default_nettype none

`include "cache_defines.svh"

package dma_pkg;

  typedef enum logic [1:0] {
    M_IDLE,   // waiting for a request
    M_WAIT,   // read latency
    M_READ,
    M_WRITE
  } mem_state_e;

  typedef logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] dma_cnt_t;

endpackage

`default_nettype wire

// ==== src/mock_memory.sv ====
// Mock word memory on the DMA link
// Serves one block read or write at a time. Reads start after a
// fixed latency, then stream the block under rd_ready.
// Contents come out of reset with a known address pattern

`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module mock_memory
  import dma_pkg::*;
(
  input  wire  clock_i,
  input  wire  rst_n_i,
  dma_if.mem   dma
);

  localparam int MEM_AW = $clog2(`MEM_WORDS);
  localparam int OFF_W  = $bits(dma_cnt_t);
  localparam int BLK_W  = MEM_AW - OFF_W;
  localparam int LAT_W  = $clog2(`MEM_LATENCY + 1);
  localparam dma_cnt_t LAST = dma_cnt_t'(`CACHE_BLOCK_WORDS - 1);
  localparam logic [`CACHE_WORD_W-1:0] INIT_KEY = 32'h5a5a0000;

  mem_state_e       state;
  dma_cnt_t         cnt;
  logic [LAT_W-1:0] lat_cnt;
  logic [BLK_W-1:0] blk_r;    // block number, wraps modulo MEM_WORDS

  logic [`CACHE_WORD_W-1:0] mem [`MEM_WORDS];

  // ====================
  // control FSM
  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      state   <= M_IDLE;
      cnt     <= '0;
      lat_cnt <= '0;
    end else begin
      case (state)
        M_IDLE: begin
          if (dma.req_v) begin
            cnt <= '0;
            if (dma.req_write_not_read) begin
              state <= M_WRITE;
            end else begin
              state   <= M_WAIT;
              lat_cnt <= LAT_W'(`MEM_LATENCY - 2);
            end
          end
        end
        M_WAIT: begin
          if (lat_cnt == '0) state <= M_READ;
          else lat_cnt <= lat_cnt - LAT_W'(1);
        end
        M_READ: begin
          if (dma.rd_ready) begin
            cnt <= cnt + dma_cnt_t'(1);
            if (cnt == LAST) state <= M_IDLE;
          end
        end
        M_WRITE: begin
          if (dma.wr_v) begin
            cnt <= cnt + dma_cnt_t'(1);
            if (cnt == LAST) state <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (dma.req_yumi) blk_r <= dma.req_addr[MEM_AW+1 : OFF_W+2];
  end

  // array comes up with word i = i ^ key
  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MEM_WORDS; i++) mem[i] <= `CACHE_WORD_W'(i) ^ INIT_KEY;
    end else if (dma.wr_yumi) begin
      mem[{blk_r, cnt}] <= dma.wr_data;
    end
  end

  assign dma.req_yumi = (state == M_IDLE) && dma.req_v;
  assign dma.rd_v     = (state == M_READ);
  assign dma.rd_data  = mem[{blk_r, cnt}];
  assign dma.wr_yumi  = (state == M_WRITE) && dma.wr_v;

  // ====================
  // checks
  a_wr_in_write: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    $rose(dma.wr_v) |-> (state == M_WRITE))
    else $error("write data offered outside a write transaction");

  a_req_aligned: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    dma.req_v |-> (dma.req_addr[OFF_W+1:0] == '0))
    else $error("unaligned block request");

endmodule

`default_nettype wire

// ==== src/test_node_client.sv ====
// Test node client
// Takes 80-bit request words, runs the packet in the low 74 bits
// through the data cache and returns one 32-bit response per
// accepted request. The cache is backed by a mock memory over DMA

`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module test_node_client
  import cache_pkg::*;
(
  input  wire                      clock_i,
  input  wire                      rst_n_i,

  // request side, valid/ready
  input  wire                      v_i,
  input  wire [79:0]               data_i,
  output logic                     ready_o,

  // response side, valid/yumi
  output logic                     v_o,
  output logic [`CACHE_WORD_W-1:0] data_o,
  input  wire                      yumi_i
);

  cache_pkt_s pkt;

  assign pkt = cache_pkt_s'(data_i[$bits(cache_pkt_s)-1:0]);  // top bits ignored

  dma_if dma_link ();

  cache_ctrl i_cache (
    .clock_i (clock_i),
    .rst_n_i (rst_n_i),
    .pkt_i   (pkt),
    .v_i     (v_i),
    .ready_o (ready_o),
    .v_o     (v_o),
    .data_o  (data_o),
    .yumi_i  (yumi_i),
    .dma     (dma_link.cache)
  );

  mock_memory i_mem (
    .clock_i (clock_i),
    .rst_n_i (rst_n_i),
    .dma     (dma_link.mem)
  );

endmodule

`default_nettype wire
